// ==== common/opl3_reg_pkg.sv ====
// Shared constants, address map and state types for the OPL3 register store and its testbench
package opl3_reg_pkg;

    // Register store geometry
    localparam int REG_DATA_WIDTH   = 8;
    localparam int REG_DEPTH        = 256;
    localparam int REG_ADDR_WIDTH   = 8;
    localparam int REG_NUM_BANKS    = 2;
    localparam int REG_BANK_WIDTH   = 1;
    // Read latency of each bank memory
    localparam int REG_OUTPUT_DELAY = 1;
    localparam logic [REG_DATA_WIDTH-1:0] REG_DEFAULT_VALUE = '0;

    // AXI4-Lite host port
    localparam int AXI_ADDR_WIDTH = 12;
    localparam int AXI_DATA_WIDTH = 32;

    // Bit 11 set selects the control half of the map
    localparam logic [AXI_ADDR_WIDTH-1:0] CTRL_ADDR = 12'h800;

    // Every response is OKAY
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Clear sequencer
    typedef enum logic {
        IDLE,
        RESETTING
    } mem_clear_state_t;

    // Slave read path
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_MEM,
        RD_RESP
    } axil_rd_state_t;

endpackage

// ==== mem/mem_simple_dual_port.sv ====
// One memory bank with a synchronous write port and a read port of 0, 1 or 2 cycles latency
`timescale 1ns/1ps

module mem_simple_dual_port #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 256,
    parameter int OUTPUT_DELAY = 1,
    parameter logic [DATA_WIDTH-1:0] DEFAULT_VALUE = '0
) (
    input  logic                     clk,
    input  logic                     wea,
    input  logic                     reb,
    input  logic [$clog2(DEPTH)-1:0] addra,
    input  logic [DATA_WIDTH-1:0]    dia,
    input  logic [$clog2(DEPTH)-1:0] addrb,
    output logic [DATA_WIDTH-1:0]    dob
);

    logic [DATA_WIDTH-1:0] ram [DEPTH];

    // Power-up contents match the clear value
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            ram[i] = DEFAULT_VALUE;
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (wea) begin
            ram[addra] <= dia;
        end
    end

    // Read port, latency set by OUTPUT_DELAY
    generate
        if (OUTPUT_DELAY == 0) begin : g_comb_read
            assign dob = ram[addrb];
        end else if (OUTPUT_DELAY == 1) begin : g_one_stage
            always_ff @(posedge clk) begin
                if (reb) begin
                    dob <= ram[addrb];
                end
            end
        end else begin : g_two_stage
            logic [DATA_WIDTH-1:0] dob_p1;

            // Both stages advance only on a read
            always_ff @(posedge clk) begin
                if (reb) begin
                    dob_p1 <= ram[addrb];
                    dob    <= dob_p1;
                end
            end
        end
    endgenerate

endmodule

// ==== mem/mem_multi_bank_reset.sv ====
// Banked register memory with one write and one read port and a sequenced clear of all banks
`timescale 1ns/1ps

module mem_multi_bank_reset
    import opl3_reg_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 256,
    parameter int OUTPUT_DELAY = 1,
    parameter logic [DATA_WIDTH-1:0] DEFAULT_VALUE = '0,
    parameter int NUM_BANKS = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             reset_mem,
    input  logic                             wea,
    input  logic                             reb,
    input  logic [$clog2(NUM_BANKS)-1:0]     banka,
    input  logic [$clog2(DEPTH)-1:0]         addra,
    input  logic [$clog2(NUM_BANKS)-1:0]     bankb,
    input  logic [$clog2(DEPTH)-1:0]         addrb,
    input  logic [DATA_WIDTH-1:0]            dia,
    output logic [DATA_WIDTH-1:0]            dob,
    output logic                             reset_mem_done_pulse
);

    localparam int BANK_WIDTH = $clog2(NUM_BANKS);
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    logic [NUM_BANKS-1:0]  wea_array;
    logic [NUM_BANKS-1:0]  reb_array;
    logic [DATA_WIDTH-1:0] dob_array [NUM_BANKS];

    // Clear sequencer state
    mem_clear_state_t      state, next_state;
    logic [BANK_WIDTH-1:0] clr_bank, next_clr_bank;
    logic [ADDR_WIDTH-1:0] clr_addr, next_clr_addr;
    logic                  done, next_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            clr_bank <= '0;
            clr_addr <= '0;
            done     <= 1'b0;
        end else begin
            state    <= next_state;
            clr_bank <= next_clr_bank;
            clr_addr <= next_clr_addr;
            done     <= next_done;
        end
    end

    always_comb begin
        next_state    = state;
        next_clr_bank = clr_bank;
        next_clr_addr = clr_addr;
        next_done     = 1'b0;

        unique case (state)
            IDLE: begin
                // Walk starts at bank 0 address 0
                next_clr_bank = '0;
                next_clr_addr = '0;
                if (reset_mem) begin
                    next_state = RESETTING;
                end
            end
            RESETTING: begin
                if (clr_addr == ADDR_WIDTH'(DEPTH - 1)) begin
                    next_clr_addr = '0;
                    if (clr_bank == BANK_WIDTH'(NUM_BANKS - 1)) begin
                        // Last location written this cycle
                        next_state = IDLE;
                        next_done  = 1'b1;
                    end else begin
                        next_clr_bank = clr_bank + 1'b1;
                    end
                end else begin
                    next_clr_addr = clr_addr + 1'b1;
                end
            end
        endcase
    end

    assign reset_mem_done_pulse = done;

    generate
        for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
            // Clear walk owns the write port, host writes dropped meanwhile
            always_comb begin
                if (state == RESETTING) begin
                    wea_array[i] = (clr_bank == BANK_WIDTH'(i));
                end else begin
                    wea_array[i] = wea && (banka == BANK_WIDTH'(i));
                end
                reb_array[i] = reb && (bankb == BANK_WIDTH'(i));
            end

            mem_simple_dual_port #(
                .DATA_WIDTH    (DATA_WIDTH),
                .DEPTH         (DEPTH),
                .OUTPUT_DELAY  (OUTPUT_DELAY),
                .DEFAULT_VALUE (DEFAULT_VALUE)
            ) i_mem_bank (
                .clk   (clk),
                .wea   (wea_array[i]),
                .reb   (reb_array[i]),
                .addra ((state == RESETTING) ? clr_addr : addra),
                .dia   ((state == RESETTING) ? DEFAULT_VALUE : dia),
                .addrb (addrb),
                .dob   (dob_array[i])
            );
        end

        // Output mux follows the bank of the read that produced the data
        if (OUTPUT_DELAY == 0) begin : g_no_delay
            assign dob = dob_array[bankb];
        end else begin : g_bank_delay
            logic [BANK_WIDTH-1:0] bankb_p [1:OUTPUT_DELAY];

            always_ff @(posedge clk) begin
                if (reb) begin
                    bankb_p[1] <= bankb;
                    for (int k = 2; k <= OUTPUT_DELAY; k++) begin
                        bankb_p[k] <= bankb_p[k-1];
                    end
                end
            end

            assign dob = dob_array[bankb_p[OUTPUT_DELAY]];
        end
    endgenerate

endmodule

// ==== verilog/axil_reg_slave.sv ====
// AXI4-Lite slave mapping host accesses onto register store writes, reads, clear and status
`timescale 1ns/1ps

module axil_reg_slave
    import opl3_reg_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    // AXI write address, data and response
    input  logic [AXI_ADDR_WIDTH-1:0]   s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [AXI_DATA_WIDTH-1:0]   s_wdata,
    input  logic [AXI_DATA_WIDTH/8-1:0] s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,

    // AXI read address and data
    input  logic [AXI_ADDR_WIDTH-1:0]   s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [AXI_DATA_WIDTH-1:0]   s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,

    // Register store side
    output logic                        mem_wea,
    output logic [REG_BANK_WIDTH-1:0]   mem_banka,
    output logic [REG_ADDR_WIDTH-1:0]   mem_addra,
    output logic [REG_DATA_WIDTH-1:0]   mem_dia,
    output logic                        mem_reb,
    output logic [REG_BANK_WIDTH-1:0]   mem_bankb,
    output logic [REG_ADDR_WIDTH-1:0]   mem_addrb,
    input  logic [REG_DATA_WIDTH-1:0]   mem_dob,
    output logic                        mem_reset_mem,
    input  logic                        reset_mem_done_pulse
);

    logic           wr_accept;
    logic           ar_accept;
    logic           busy, busy_next;
    logic           wr_ctrl_hit;
    logic           rd_ctrl_hit;
    logic           rd_ctrl, rd_status;
    axil_rd_state_t rd_state, rd_state_next;

    // Control word matches on the word address, byte offset ignored
    assign wr_ctrl_hit = (s_awaddr[AXI_ADDR_WIDTH-1:2] == CTRL_ADDR[AXI_ADDR_WIDTH-1:2]);
    assign rd_ctrl_hit = (s_araddr[AXI_ADDR_WIDTH-1:2] == CTRL_ADDR[AXI_ADDR_WIDTH-1:2]);

    // Both write channels taken together, one response outstanding at most
    assign wr_accept = s_awvalid && s_wvalid && !s_bvalid && !busy;
    assign s_awready = wr_accept;
    assign s_wready  = wr_accept;

    // Register writes go straight to the store in the accept cycle
    assign mem_wea   = wr_accept && !s_awaddr[11] && s_wstrb[0];
    assign mem_banka = s_awaddr[10];
    assign mem_addra = s_awaddr[9:2];
    assign mem_dia   = s_wdata[REG_DATA_WIDTH-1:0];

    // Clear starts on a 1 in bit 0 of the control word
    assign mem_reset_mem = wr_accept && wr_ctrl_hit && s_wstrb[0] && s_wdata[0];

    always_comb begin
        busy_next = busy;
        if (mem_reset_mem) begin
            busy_next = 1'b1;
        end else if (reset_mem_done_pulse) begin
            busy_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            s_bvalid <= 1'b0;
        end else begin
            busy <= busy_next;
            if (wr_accept) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    assign s_bresp = AXI_RESP_OKAY;

    // Read issue, memory sees the request in the accept cycle
    assign ar_accept = s_arvalid && s_arready;
    assign mem_reb   = ar_accept && !s_araddr[11];
    assign mem_bankb = s_araddr[10];
    assign mem_addrb = s_araddr[9:2];

    always_comb begin
        rd_state_next = rd_state;
        unique case (rd_state)
            RD_IDLE: begin
                if (ar_accept) begin
                    rd_state_next = RD_MEM;
                end
            end
            // One cycle of memory latency
            RD_MEM:  rd_state_next = RD_RESP;
            RD_RESP: begin
                if (s_rready) begin
                    rd_state_next = RD_IDLE;
                end
            end
            default: rd_state_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state  <= RD_IDLE;
            s_arready <= 1'b0;
        end else begin
            rd_state  <= rd_state_next;
            // Registered so it rises only once reset is gone
            s_arready <= (rd_state_next == RD_IDLE) && !busy_next;
        end
    end

    // Source of the pending read
    always_ff @(posedge clk) begin
        if (ar_accept) begin
            rd_ctrl   <= s_araddr[11];
            rd_status <= rd_ctrl_hit;
        end
    end

    // Data captured once the memory output is valid
    always_ff @(posedge clk) begin
        if (rd_state == RD_MEM) begin
            if (rd_ctrl) begin
                s_rdata <= {{(AXI_DATA_WIDTH-1){1'b0}}, rd_status && busy};
            end else begin
                s_rdata <= {{(AXI_DATA_WIDTH-REG_DATA_WIDTH){1'b0}}, mem_dob};
            end
        end
    end

    assign s_rvalid = (rd_state == RD_RESP);
    assign s_rresp  = AXI_RESP_OKAY;

endmodule

// ==== verilog/opl3_reg_ram_top.sv ====
// Top level of the OPL3 register store, AXI4-Lite slave in front of the banked memory
`timescale 1ns/1ps

module opl3_reg_ram_top
    import opl3_reg_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic [AXI_ADDR_WIDTH-1:0]   s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [AXI_DATA_WIDTH-1:0]   s_wdata,
    input  logic [AXI_DATA_WIDTH/8-1:0] s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,

    input  logic [AXI_ADDR_WIDTH-1:0]   s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [AXI_DATA_WIDTH-1:0]   s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready
);

    // Slave to memory
    logic                      mem_wea;
    logic [REG_BANK_WIDTH-1:0] mem_banka;
    logic [REG_ADDR_WIDTH-1:0] mem_addra;
    logic [REG_DATA_WIDTH-1:0] mem_dia;
    logic                      mem_reb;
    logic [REG_BANK_WIDTH-1:0] mem_bankb;
    logic [REG_ADDR_WIDTH-1:0] mem_addrb;
    logic [REG_DATA_WIDTH-1:0] mem_dob;
    logic                      mem_reset_mem;
    logic                      reset_mem_done_pulse;

    axil_reg_slave i_axil_reg_slave (
        .clk                  (clk),
        .reset                (reset),
        .s_awaddr             (s_awaddr),
        .s_awvalid            (s_awvalid),
        .s_awready            (s_awready),
        .s_wdata              (s_wdata),
        .s_wstrb              (s_wstrb),
        .s_wvalid             (s_wvalid),
        .s_wready             (s_wready),
        .s_bresp              (s_bresp),
        .s_bvalid             (s_bvalid),
        .s_bready             (s_bready),
        .s_araddr             (s_araddr),
        .s_arvalid            (s_arvalid),
        .s_arready            (s_arready),
        .s_rdata              (s_rdata),
        .s_rresp              (s_rresp),
        .s_rvalid             (s_rvalid),
        .s_rready             (s_rready),
        .mem_wea              (mem_wea),
        .mem_banka            (mem_banka),
        .mem_addra            (mem_addra),
        .mem_dia              (mem_dia),
        .mem_reb              (mem_reb),
        .mem_bankb            (mem_bankb),
        .mem_addrb            (mem_addrb),
        .mem_dob              (mem_dob),
        .mem_reset_mem        (mem_reset_mem),
        .reset_mem_done_pulse (reset_mem_done_pulse)
    );

    mem_multi_bank_reset #(
        .DATA_WIDTH    (REG_DATA_WIDTH),
        .DEPTH         (REG_DEPTH),
        .OUTPUT_DELAY  (REG_OUTPUT_DELAY),
        .DEFAULT_VALUE (REG_DEFAULT_VALUE),
        .NUM_BANKS     (REG_NUM_BANKS)
    ) i_mem_multi_bank_reset (
        .clk                  (clk),
        .reset                (reset),
        .reset_mem            (mem_reset_mem),
        .wea                  (mem_wea),
        .reb                  (mem_reb),
        .banka                (mem_banka),
        .addra                (mem_addra),
        .bankb                (mem_bankb),
        .addrb                (mem_addrb),
        .dia                  (mem_dia),
        .dob                  (mem_dob),
        .reset_mem_done_pulse (reset_mem_done_pulse)
    );

endmodule

// ==== bench/axil_reg_slave_asserts.sv ====
// Concurrent handshake checks, bound into every instance of the AXI4-Lite register slave
`timescale 1ns/1ps

module axil_reg_slave_asserts
    import opl3_reg_pkg::*;
(
    input logic                      clk,
    input logic                      reset,
    input logic                      s_awready,
    input logic                      s_wready,
    input logic                      s_arready,
    input logic [1:0]                s_bresp,
    input logic                      s_bvalid,
    input logic                      s_bready,
    input logic [AXI_DATA_WIDTH-1:0] s_rdata,
    input logic [1:0]                s_rresp,
    input logic                      s_rvalid,
    input logic                      s_rready,
    input logic                      mem_reset_mem,
    input logic                      reset_mem_done_pulse
);

    // Number of failed checks
    int failures = 0;

    // Cycles of the clear walk still ahead, one location per cycle
    int clear_left;

    always_ff @(posedge clk) begin
        if (reset) begin
            clear_left <= 0;
        end else if (mem_reset_mem) begin
            clear_left <= REG_NUM_BANKS * REG_DEPTH;
        end else if (clear_left != 0) begin
            clear_left <= clear_left - 1;
        end
    end

    // Write response waits for bready
    bvalid_held: assert property (@(posedge clk) disable iff (reset)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
    else begin
        $error("bvalid or bresp changed before bready");
        failures++;
    end

    // Read data waits for rready
    rvalid_held: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
    else begin
        $error("rvalid, rdata or rresp changed before rready");
        failures++;
    end

    // No host traffic while the clear walks the banks
    ready_low_when_busy: assert property (@(posedge clk) disable iff (reset)
        clear_left != 0 |-> !s_awready && !s_wready && !s_arready)
    else begin
        $error("ready raised while the clear is busy");
        failures++;
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        reset_mem_done_pulse |=> !reset_mem_done_pulse)
    else begin
        $error("clear done pulse lasted more than one cycle");
        failures++;
    end

endmodule

bind axil_reg_slave axil_reg_slave_asserts i_axil_reg_slave_asserts (
    .clk                  (clk),
    .reset                (reset),
    .s_awready            (s_awready),
    .s_wready             (s_wready),
    .s_arready            (s_arready),
    .s_bresp              (s_bresp),
    .s_bvalid             (s_bvalid),
    .s_bready             (s_bready),
    .s_rdata              (s_rdata),
    .s_rresp              (s_rresp),
    .s_rvalid             (s_rvalid),
    .s_rready             (s_rready),
    .mem_reset_mem        (mem_reset_mem),
    .reset_mem_done_pulse (reset_mem_done_pulse)
);

// ==== bench/tb_opl3_reg_ram.sv ====
// Testbench for the OPL3 register store, drives the AXI4-Lite port and checks reads against a model
`timescale 1ns/1ps

module tb_opl3_reg_ram
    import opl3_reg_pkg::*;
();

    logic                        clk;
    logic                        reset;
    logic [AXI_ADDR_WIDTH-1:0]   s_awaddr;
    logic                        s_awvalid;
    logic                        s_awready;
    logic [AXI_DATA_WIDTH-1:0]   s_wdata;
    logic [AXI_DATA_WIDTH/8-1:0] s_wstrb;
    logic                        s_wvalid;
    logic                        s_wready;
    logic [1:0]                  s_bresp;
    logic                        s_bvalid;
    logic                        s_bready;
    logic [AXI_ADDR_WIDTH-1:0]   s_araddr;
    logic                        s_arvalid;
    logic                        s_arready;
    logic [AXI_DATA_WIDTH-1:0]   s_rdata;
    logic [1:0]                  s_rresp;
    logic                        s_rvalid;
    logic                        s_rready;

    // Expected register contents and busy flag
    logic [REG_DATA_WIDTH-1:0] model [REG_NUM_BANKS][REG_DEPTH];
    logic                      model_busy;

    // Read responses waiting for the compare process
    logic [AXI_ADDR_WIDTH-1:0] rsp_addr_q [$];
    logic [AXI_DATA_WIDTH-1:0] rsp_exp_q [$];
    logic [AXI_DATA_WIDTH-1:0] rsp_got_q [$];

    int          mismatch_errors;
    int          check_errors;
    int          timeout_errors;
    int          seed;
    int unsigned cycle;

    opl3_reg_ram_top i_opl3_reg_ram_top (
        .clk       (clk),
        .reset     (reset),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Longer than a full clear of both banks
    function automatic int wait_limit();
        return 4 * REG_NUM_BANKS * REG_DEPTH;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'({1'b0, r[30:0]}) % n;
    endfunction

    function automatic logic [AXI_ADDR_WIDTH-1:0] reg_addr(
        input logic                      bank,
        input logic [REG_ADDR_WIDTH-1:0] idx
    );
        return {1'b0, bank, idx, 2'b00};
    endfunction

    // Expected rdata from the address map
    function automatic logic [AXI_DATA_WIDTH-1:0] ref_read(input logic [AXI_ADDR_WIDTH-1:0] addr);
        if (addr[11]) begin
            // Upper half holds only the control word
            if (addr[11:2] == CTRL_ADDR[11:2]) begin
                return {{(AXI_DATA_WIDTH-1){1'b0}}, model_busy};
            end
            return '0;
        end
        return {{(AXI_DATA_WIDTH-REG_DATA_WIDTH){1'b0}}, model[addr[10]][addr[9:2]]};
    endfunction

    task automatic clear_model();
        foreach (model[b, r]) begin
            model[b][r] = REG_DEFAULT_VALUE;
        end
    endtask

    task automatic axil_write(
        input logic [AXI_ADDR_WIDTH-1:0]   addr,
        input logic [AXI_DATA_WIDTH-1:0]   data,
        input logic [AXI_DATA_WIDTH/8-1:0] strb,
        input int                          bdelay
    );
        int         cnt;
        bit         accepted;
        logic [1:0] resp;

        @(posedge clk);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= strb;
        s_wvalid  <= 1'b1;
        // Address and data go in the same cycle
        cnt = 0;
        @(negedge clk);
        while (!(s_awready && s_wready) && cnt < wait_limit()) begin
            @(negedge clk);
            cnt++;
        end
        accepted = s_awready && s_wready;
        @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        if (!accepted) begin
            $display("Timeout at %0t: write to 0x%03h was never accepted", $time, addr);
            timeout_errors++;
            return;
        end
        // Model follows every accepted write
        if (!addr[11] && strb[0]) begin
            model[addr[10]][addr[9:2]] = data[REG_DATA_WIDTH-1:0];
        end else if (addr[11:2] == CTRL_ADDR[11:2] && strb[0] && data[0]) begin
            clear_model();
        end
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!s_bvalid && cnt < wait_limit());
        if (!s_bvalid) begin
            $display("Timeout at %0t: no write response for 0x%03h", $time, addr);
            timeout_errors++;
            return;
        end
        assert (cnt == 1) else begin
            $display("Write 0x%03h at %0t: bvalid came %0d cycles after accept, not 1",
                     addr, $time, cnt);
            check_errors++;
        end
        resp = s_bresp;
        assert (resp == AXI_RESP_OKAY) else begin
            $display("[FAIL] %0t: write 0x%03h bresp expected %0d got %0d",
                     $time, addr, AXI_RESP_OKAY, resp);
            check_errors++;
        end
        // Response must sit still while bready is low
        repeat (bdelay) begin
            @(negedge clk);
            assert (s_bvalid && s_bresp == resp) else begin
                $display("Write 0x%03h at %0t: response dropped before bready", addr, $time);
                check_errors++;
            end
        end
        @(posedge clk);
        s_bready <= 1'b1;
        @(posedge clk);
        s_bready <= 1'b0;
    endtask

    task automatic axil_read(
        input  logic [AXI_ADDR_WIDTH-1:0] addr,
        input  int                        rdelay,
        input  bit                        check,
        output logic [AXI_DATA_WIDTH-1:0] data
    );
        int                        cnt;
        bit                        accepted;
        logic [AXI_DATA_WIDTH-1:0] expected;

        data = '0;
        @(posedge clk);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        // Stalls here for the length of a clear
        cnt = 0;
        @(negedge clk);
        while (!s_arready && cnt < wait_limit()) begin
            @(negedge clk);
            cnt++;
        end
        accepted = s_arready;
        expected = ref_read(addr);
        @(posedge clk);
        s_arvalid <= 1'b0;
        if (!accepted) begin
            $display("Timeout at %0t: read of 0x%03h was never accepted", $time, addr);
            timeout_errors++;
            return;
        end
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!s_rvalid && cnt < wait_limit());
        if (!s_rvalid) begin
            $display("Timeout at %0t: no read data for 0x%03h", $time, addr);
            timeout_errors++;
            return;
        end
        // Memory latency plus the rdata register
        assert (cnt == 2) else begin
            $display("Read 0x%03h at %0t: rvalid came %0d cycles after accept, not 2",
                     addr, $time, cnt);
            check_errors++;
        end
        data = s_rdata;
        assert (s_rresp == AXI_RESP_OKAY) else begin
            $display("[FAIL] %0t: read 0x%03h rresp expected %0d got %0d",
                     $time, addr, AXI_RESP_OKAY, s_rresp);
            check_errors++;
        end
        repeat (rdelay) begin
            @(negedge clk);
            assert (s_rvalid && s_rdata == data) else begin
                $display("Read 0x%03h at %0t: data changed or dropped before rready", addr, $time);
                check_errors++;
            end
        end
        @(posedge clk);
        s_rready <= 1'b1;
        @(posedge clk);
        s_rready <= 1'b0;
        if (check) begin
            rsp_addr_q.push_back(addr);
            rsp_exp_q.push_back(expected);
            rsp_got_q.push_back(data);
        end
    endtask

    // Compare process
    always @(negedge clk) begin : compare_responses
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [AXI_DATA_WIDTH-1:0] exp_data;
        logic [AXI_DATA_WIDTH-1:0] got_data;
        while (rsp_addr_q.size() > 0) begin
            addr     = rsp_addr_q.pop_front();
            exp_data = rsp_exp_q.pop_front();
            got_data = rsp_got_q.pop_front();
            assert (got_data == exp_data) else begin
                $display("[FAIL] %0t: read 0x%03h expected 0x%08h got 0x%08h",
                         $time, addr, exp_data, got_data);
                mismatch_errors++;
            end
        end
    end

    initial begin
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [AXI_DATA_WIDTH-1:0] rnd;
        logic [AXI_DATA_WIDTH-1:0] rd_data;
        logic [AXI_ADDR_WIDTH-1:0] wr_list [$];
        int unsigned               start_cycle;
        int                        polls;
        int                        assert_failures;

        seed            = 41670;
        mismatch_errors = 0;
        check_errors    = 0;
        timeout_errors  = 0;
        cycle           = 0;
        model_busy      = 1'b0;
        clear_model();
        reset     = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // After reset
        @(negedge clk);
        assert (!s_awready && !s_wready && !s_bvalid && !s_rvalid) else begin
            $display("[FAIL] %0t: handshake outputs not low after reset", $time);
            check_errors++;
        end
        @(negedge clk);
        assert (s_arready) else begin
            $display("[FAIL] %0t: arready did not rise in the first cycle after reset", $time);
            check_errors++;
        end
        axil_read(CTRL_ADDR, 0, 1'b1, rd_data);

        // Random writes then readback
        for (int i = 0; i < 200; i++) begin
            rnd  = $random(seed);
            addr = reg_addr(rnd[8], rnd[7:0]);
            wr_list.push_back(addr);
            rnd = $random(seed);
            axil_write(addr, rnd, 4'hf, 0);
        end
        foreach (wr_list[i]) begin
            axil_read(wr_list[i], 0, 1'b1, rd_data);
        end

        // Same register in both banks, then a write with lane 0 off
        axil_write(reg_addr(1'b0, 8'h45), 32'h0000_00a5, 4'hf, 0);
        axil_write(reg_addr(1'b1, 8'h45), 32'h0000_005a, 4'hf, 0);
        axil_read(reg_addr(1'b0, 8'h45), 0, 1'b1, rd_data);
        axil_read(reg_addr(1'b1, 8'h45), 0, 1'b1, rd_data);
        axil_write(reg_addr(1'b0, 8'h45), 32'h0000_00ff, 4'he, 0);
        axil_read(reg_addr(1'b0, 8'h45), 0, 1'b1, rd_data);

        // Status read issued alongside the clear start so it sees busy
        model_busy = 1'b1;
        fork
            axil_write(CTRL_ADDR, 32'h1, 4'h1, 0);
            axil_read(CTRL_ADDR, 0, 1'b1, rd_data);
        join
        start_cycle = cycle;
        // Status reads are held off until the walk ends
        polls   = 0;
        rd_data = 32'h1;
        while (rd_data[0] && polls < 16) begin
            axil_read(CTRL_ADDR, 0, 1'b0, rd_data);
            polls++;
        end
        model_busy = 1'b0;
        assert (!rd_data[0]) else begin
            $display("Clear still busy after %0d status polls", polls);
            timeout_errors++;
        end
        assert (cycle - start_cycle >= 32'(REG_NUM_BANKS * REG_DEPTH)) else begin
            $display("Clear ended after %0d cycles, too fast for one location per cycle",
                     cycle - start_cycle);
            check_errors++;
        end
        for (int b = 0; b < REG_NUM_BANKS; b++) begin
            for (int r = 0; r < REG_DEPTH; r++) begin
                axil_read(reg_addr(b[0], r[7:0]), 0, 1'b1, rd_data);
            end
        end

        // Back-pressure on both response channels
        wr_list.delete();
        for (int i = 0; i < 40; i++) begin
            rnd  = $random(seed);
            addr = reg_addr(rnd[8], rnd[7:0]);
            wr_list.push_back(addr);
            rnd = $random(seed);
            axil_write(addr, rnd, 4'hf, rand_below(11));
        end
        foreach (wr_list[i]) begin
            axil_read(wr_list[i], rand_below(11), 1'b1, rd_data);
        end
        axil_read(CTRL_ADDR, rand_below(11), 1'b1, rd_data);

        repeat (4) @(posedge clk);
        assert_failures = i_opl3_reg_ram_top.i_axil_reg_slave.i_axil_reg_slave_asserts.failures;
        $display("Errors: %0d mismatch, %0d protocol, %0d timeout, %0d assertion",
                 mismatch_errors, check_errors, timeout_errors, assert_failures);
        if (mismatch_errors + check_errors + timeout_errors + assert_failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/opl3_reg_pkg.sv
mem/mem_simple_dual_port.sv
mem/mem_multi_bank_reset.sv
verilog/axil_reg_slave.sv
verilog/opl3_reg_ram_top.sv
bench/axil_reg_slave_asserts.sv
bench/tb_opl3_reg_ram.sv

// ==== Makefile ====
# Verilator build and run of the OPL3 register store testbench

VERILATOR ?= verilator
TOP       ?= tb_opl3_reg_ram
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= PASS: all tests

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIMFLAGS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
